// File: filelist.f
+incdir+rtl
+incdir+testbench
rtl/parity_pkg.sv
rtl/booth_pkg.sv
rtl/pipe_stage.sv
rtl/operand_decode.sv
rtl/partial_product_sum.sv
rtl/parity_cfg_regs.sv
rtl/pmu_top.sv
testbench/tb_pmu_top.sv

// File: run_sim.sh
#!/bin/sh
# build and run the pmu testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    -f filelist.f --top-module tb_pmu_top \
    --Mdir obj_dir -o sim_pmu

./obj_dir/sim_pmu > sim.log 2>&1
cat sim.log

if grep -q "Done: errors found" sim.log; then
    echo "simulation reported failures"
    exit 1
fi

echo "simulation passed"
exit 0

// File: testbench/tb_pmu_model.svh
// pmu model: expected product and parity tag derived from the multiply rules
`ifndef TB_PMU_MODEL_SVH
`define TB_PMU_MODEL_SVH

// signed 8x8 multiply kept at 16 bits
function automatic logic [15:0] ref_product(
    input logic signed [7:0] a,
    input logic signed [7:0] b
);
    logic signed [15:0] wa;
    logic signed [15:0] wb;
    wa = a;   // sign-extend before the multiply
    wb = b;
    return wa * wb;
endfunction

// tag is {parity bit, odd-family flag}
function automatic logic [1:0] ref_parity(
    input logic [1:0] mode,
    input logic [7:0] d
);
    case (mode)
        2'b01:   return {~(^d), 1'b0};  // even parity bit
        2'b10:   return {^d, 1'b1};     // odd parity bit
        2'b11:   return {~(^d), 1'b1};  // inverted odd bit
        default: return 2'b00;
    endcase
endfunction

`endif

// File: testbench/tb_pmu_top.sv
// pmu testbench with random and directed traffic checked against a reference model
`include "pmu_config.svh"

module tb_pmu_top
    import parity_pkg::*;
    import booth_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    `include "tb_pmu_model.svh"

    localparam int WAIT_LIMIT = 2000;   // cycles per wait

    logic                  clk;
    logic                  rst;
    logic                  in_valid;
    logic                  in_ready;
    operand_t              multiplier;
    operand_t              multiplicand;
    logic [7:0]            data;
    logic                  out_valid;
    logic                  out_ready;
    product_t              product;
    parity_tag_t           parity;
    logic                  cfg_we;
    parity_mode_t          cfg_mode;
    logic [`PMU_CNT_W-1:0] result_count;

    logic [15:0] exp_prod_q[$];
    logic [1:0]  exp_tag_q[$];
    int          stamp_q[$];        // acceptance cycle of each entry
    logic [1:0]  tb_mode;           // mode as the DUT should hold it
    int          cycle;
    int          fire_count;
    int          last_latency;
    int          errors;
    int          checks;
    int          tests;
    logic        bp_enable;
    logic        timed_out;
    logic        holding;
    logic [15:0] held_prod;
    logic [1:0]  held_tag;

    pmu_top uut (
        .clk          (clk),
        .rst          (rst),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .multiplier   (multiplier),
        .multiplicand (multiplicand),
        .data         (data),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .product      (product),
        .parity       (parity),
        .cfg_we       (cfg_we),
        .cfg_mode     (cfg_mode),
        .result_count (result_count)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check_equal(input string name, input logic [15:0] exp, input logic [15:0] got);
        checks++;
        assert (got == exp) else begin
            $display("MISMATCH time=%0t %s expected=%h actual=%h", $time, name, exp, got);
            errors++;
        end
    endtask

    // scoreboard sees pre-edge values on each rising edge
    always @(posedge clk) begin
        cycle++;
        if (rst) begin
            tb_mode = 2'b00;
            holding = 1'b0;
        end else begin
            if (in_valid && in_ready) begin
                exp_prod_q.push_back(ref_product(multiplier, multiplicand));
                exp_tag_q.push_back(ref_parity(tb_mode, data));
                stamp_q.push_back(cycle);
            end
            if (cfg_we)
                tb_mode = cfg_mode;     // later requests only
            if (holding) begin
                check_equal("out_valid", 16'd1, {15'd0, out_valid});
                check_equal("product", held_prod, product);
                check_equal("parity", {14'd0, held_tag}, {14'd0, parity});
            end
            if (out_valid && out_ready) begin
                fire_count++;
                assert (exp_prod_q.size() != 0) else begin
                    $display("ERROR time=%0t a result came out with no request in flight",
                             $time);
                    errors++;
                end
                if (exp_prod_q.size() != 0) begin
                    check_equal("product", exp_prod_q.pop_front(), product);
                    check_equal("parity", {14'd0, exp_tag_q.pop_front()}, {14'd0, parity});
                    last_latency = cycle - stamp_q.pop_front();
                end
            end
            holding   = out_valid && !out_ready;
            held_prod = product;
            held_tag  = parity;
        end
    end

    // random back-pressure when enabled
    always @(negedge clk) begin
        out_ready = bp_enable ? 1'($urandom_range(1)) : 1'b1;
    end

    task automatic send_req(input logic [7:0] a, input logic [7:0] b, input logic [7:0] d);
        int  n;
        logic accepted;
        n = 0;
        accepted = 1'b0;
        @(negedge clk);
        in_valid     = 1'b1;
        multiplier   = a;
        multiplicand = b;
        data         = d;
        while (!accepted && n < WAIT_LIMIT) begin
            @(posedge clk);
            accepted = in_ready;
            n++;
        end
        if (!accepted) begin
            $display("ERROR time=%0t request was never accepted", $time);
            errors++;
            timed_out = 1'b1;
        end
    endtask

    task automatic stop_requests();
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic write_mode(input parity_mode_t m);
        @(negedge clk);
        in_valid = 1'b0;
        cfg_we   = 1'b1;
        cfg_mode = m;
        @(negedge clk);
        cfg_we   = 1'b0;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while ((exp_prod_q.size() != 0 || out_valid) && n < WAIT_LIMIT);
        if (exp_prod_q.size() != 0 || out_valid) begin
            $display("ERROR time=%0t pipeline did not drain, %0d results missing", $time,
                     exp_prod_q.size());
            errors++;
            timed_out = 1'b1;
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        tests++;
        if (errors == err_before)
            $display("test %0d %s: ok", tests, name);
        else
            $display("test %0d %s: %0d errors", tests, name, errors - err_before);
    endtask

    initial begin : main
        int base;
        int sent;
        int burst;
        void'($urandom(84));
        rst = 1'b1;
        in_valid = 1'b0;
        multiplier = '0;
        multiplicand = '0;
        data = '0;
        out_ready = 1'b1;
        cfg_we = 1'b0;
        cfg_mode = PAR_NONE;
        bp_enable = 1'b0;
        timed_out = 1'b0;
        errors = 0;
        checks = 0;
        tests = 0;
        cycle = 0;
        fire_count = 0;
        repeat (10) @(negedge clk);
        rst = 1'b0;

        base = errors;
        @(negedge clk);
        check_equal("out_valid", 16'd0, {15'd0, out_valid});
        check_equal("in_ready", 16'd1, {15'd0, in_ready});
        check_equal("result_count", 16'd0, 16'(result_count));
        report_test("reset state", base);

        base = errors;
        send_req(8'h80, 8'h80, 8'h00);   // -128 x -128
        send_req(8'h80, 8'h7f, 8'h5a);
        send_req(8'h7f, 8'h7f, 8'hff);
        send_req(8'h00, 8'hfb, 8'h01);   // 0 x -5
        send_req(8'h01, 8'hff, 8'h80);
        send_req(8'hff, 8'hff, 8'h3c);
        stop_requests();
        wait_drain();
        report_test("directed corners", base);

        base = errors;
        if (!timed_out) begin
            send_req(8'h13, 8'hd7, 8'h21);
            stop_requests();
            wait_drain();
            check_equal("latency", 16'd2, 16'(last_latency));
        end
        report_test("two-cycle latency", base);

        base = errors;
        sent = 0;
        while (sent < 300 && !timed_out) begin
            burst = 1 + $urandom_range(19);
            for (int k = 0; k < burst && sent < 300 && !timed_out; k++) begin
                send_req(8'($urandom), 8'($urandom), 8'($urandom));
                sent++;
            end
            write_mode(parity_mode_t'($urandom_range(3)));
        end
        stop_requests();
        wait_drain();
        report_test("random traffic, all modes", base);

        base = errors;
        @(posedge clk);
        bp_enable = 1'b1;
        for (int k = 0; k < 150 && !timed_out; k++)
            send_req(8'($urandom), 8'($urandom), 8'($urandom));
        stop_requests();
        wait_drain();
        @(posedge clk);
        bp_enable = 1'b0;
        report_test("random back-pressure", base);

        base = errors;
        @(negedge clk);
        check_equal("result_count", 16'(fire_count), 16'(result_count));
        report_test("result count", base);

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

// File: rtl/pmu_top.sv
// pmu top: two-stage pipelined booth multiplier with parity-tagged results
`include "pmu_config.svh"

module pmu_top
    import parity_pkg::*;
    import booth_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    // request
    input  logic                  in_valid,
    output logic                  in_ready,
    input  operand_t              multiplier,
    input  operand_t              multiplicand,
    input  logic [7:0]            data,
    // result
    output logic                  out_valid,
    input  logic                  out_ready,
    output product_t              product,
    output parity_tag_t           parity,
    // configuration and status
    input  logic                  cfg_we,
    input  parity_mode_t          cfg_mode,
    output logic [`PMU_CNT_W-1:0] result_count
);

    parity_mode_t mode;
    decode_word_t dec_word, dec_q;
    result_word_t res_word, res_q;
    logic         dec_valid, dec_ready;
    logic         out_fire;

    operand_decode u_decode (
        .multiplier   (multiplier),
        .multiplicand (multiplicand),
        .data         (data),
        .mode         (mode),
        .decoded      (dec_word)
    );

    pipe_stage #(.payload_t(decode_word_t)) stage_decode (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .in_payload  (dec_word),
        .out_valid   (dec_valid),
        .out_ready   (dec_ready),
        .out_payload (dec_q)
    );

    partial_product_sum u_sum (
        .decoded (dec_q),
        .result  (res_word)
    );

    pipe_stage #(.payload_t(result_word_t)) stage_result (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (dec_valid),
        .in_ready    (dec_ready),
        .in_payload  (res_word),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_payload (res_q)
    );

    assign out_fire = out_valid & out_ready;   // one delivered result
    assign product  = res_q.prod;
    assign parity   = res_q.tag;

    parity_cfg_regs u_cfg (
        .clk          (clk),
        .rst          (rst),
        .cfg_we       (cfg_we),
        .cfg_mode     (cfg_mode),
        .mode         (mode),
        .out_fire     (out_fire),
        .result_count (result_count)
    );

endmodule

// File: rtl/parity_cfg_regs.sv
// parity config regs: tag mode register and delivered-result counter
`include "pmu_config.svh"

module parity_cfg_regs
    import parity_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    // single-strobe write port
    input  logic                  cfg_we,
    input  parity_mode_t          cfg_mode,
    output parity_mode_t          mode,
    // output handshake of the datapath
    input  logic                  out_fire,
    output logic [`PMU_CNT_W-1:0] result_count
);

    parity_mode_t          mode_q;
    logic [`PMU_CNT_W-1:0] count_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            mode_q <= PAR_NONE;
        end else if (cfg_we) begin
            mode_q <= cfg_mode;   // used from the next accepted request on
        end
    end

    // wraps at full scale
    always_ff @(posedge clk) begin
        if (rst) begin
            count_q <= '0;
        end else if (out_fire) begin
            count_q <= count_q + 1'b1;
        end
    end

    assign mode         = mode_q;
    assign result_count = count_q;

endmodule

// File: rtl/partial_product_sum.sv
// partial product sum: carry-save tree over booth terms and final adder
`include "pmu_config.svh"

module partial_product_sum
    import booth_pkg::*;
(
    input  decode_word_t decoded,
    output result_word_t result
);

    logic [`PMU_PROD_W-1:0] sum_1, carry_1;    // first 3:2 level
    logic [`PMU_PROD_W-1:0] sum_2, carry_2;    // second 3:2 level
    logic [`PMU_PROD_W-1:0] total;

    // 3:2 compressor, bitwise sum
    function automatic logic [`PMU_PROD_W-1:0] csa_sum(
        input logic [`PMU_PROD_W-1:0] a,
        input logic [`PMU_PROD_W-1:0] b,
        input logic [`PMU_PROD_W-1:0] c
    );
        return a ^ b ^ c;
    endfunction

    // 3:2 compressor, majority moved up one weight
    function automatic logic [`PMU_PROD_W-1:0] csa_carry(
        input logic [`PMU_PROD_W-1:0] a,
        input logic [`PMU_PROD_W-1:0] b,
        input logic [`PMU_PROD_W-1:0] c
    );
        return ((a & b) | (a & c) | (b & c)) << 1;
    endfunction

    assign sum_1   = csa_sum(decoded.pp[0], decoded.pp[1], decoded.pp[2]);
    assign carry_1 = csa_carry(decoded.pp[0], decoded.pp[1], decoded.pp[2]);
    assign sum_2   = csa_sum(sum_1, carry_1, decoded.pp[3]);
    assign carry_2 = csa_carry(sum_1, carry_1, decoded.pp[3]);

    // carry out beyond bit 15 is dropped, two's complement wraps
    assign total = sum_2 + carry_2;

    always_comb begin
        result.prod = product_t'(total);
        result.tag  = decoded.tag;     // tag rides along untouched
    end

endmodule

// File: rtl/operand_decode.sv
// operand decode: radix-4 booth recoding into partial products plus parity tag
`include "pmu_config.svh"

module operand_decode
    import parity_pkg::*;
    import booth_pkg::*;
(
    input  operand_t     multiplier,
    input  operand_t     multiplicand,
    input  logic [7:0]   data,
    input  parity_mode_t mode,
    output decode_word_t decoded
);

    logic [`PMU_OP_W:0] mr_ext;     // multiplier with implied zero below bit 0
    product_t           mcand_ext;  // sign-extended multiplicand
    product_t           mcand_dbl;
    pp_array_t          pp;
    parity_tag_t        tag;
    logic               even_p;
    logic               odd_p;

    assign mr_ext    = {multiplier, 1'b0};
    assign mcand_ext = {{(`PMU_PROD_W - `PMU_OP_W){multiplicand[`PMU_OP_W-1]}}, multiplicand};
    assign mcand_dbl = mcand_ext <<< 1;

    // one overlapping triplet per digit
    always_comb begin
        logic [2:0] triplet;
        product_t   sel;
        for (int i = 0; i < `PMU_DIGITS; i++) begin
            triplet = mr_ext[2*i +: 3];
            case (triplet)
                3'b001, 3'b010: sel = mcand_ext;    // +1
                3'b011:         sel = mcand_dbl;    // +2
                3'b100:         sel = -mcand_dbl;   // -2
                3'b101, 3'b110: sel = -mcand_ext;   // -1
                default:        sel = '0;           // 000 and 111
            endcase
            pp[i] = sel <<< (2 * i);
        end
    end

    assign even_p = ~^data;
    assign odd_p  = ^data;

    // tag rule per mode
    always_comb begin
        case (mode)
            PAR_EVEN: tag = '{parity_bit: even_p, odd_flag: 1'b0};
            PAR_ODD:  tag = '{parity_bit: odd_p, odd_flag: 1'b1};
            PAR_INV:  tag = '{parity_bit: ~odd_p, odd_flag: 1'b1};
            default:  tag = '{parity_bit: 1'b0, odd_flag: 1'b0};
        endcase
    end

    always_comb begin
        decoded.pp  = pp;
        decoded.tag = tag;
    end

endmodule

// File: rtl/pipe_stage.sv
// pipe stage: one-entry valid/ready register holding a generic payload
module pipe_stage #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    // upstream side
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_payload,
    // downstream side
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_payload
);

    logic     full;
    logic     load;
    payload_t payload_q;

    // room when empty or when the held entry leaves this cycle
    assign in_ready = ~full | out_ready;
    assign load     = in_valid & in_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            full <= 1'b0;
        end else if (load) begin
            full <= 1'b1;
        end else if (out_ready) begin
            full <= 1'b0;   // drained, nothing new behind it
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            payload_q <= in_payload;
        end
    end

    assign out_valid   = full;
    assign out_payload = payload_q;

endmodule

// File: rtl/booth_pkg.sv
// booth package: operand, product and pipeline payload types of the multiplier
`include "pmu_config.svh"

package booth_pkg;
    import parity_pkg::*;

    // signed operands and product
    typedef logic signed [`PMU_OP_W-1:0]   operand_t;
    typedef logic signed [`PMU_PROD_W-1:0] product_t;

    // one entry per booth digit, already sign-extended and shifted
    typedef product_t [`PMU_DIGITS-1:0] pp_array_t;

    // first stage payload, partial products plus tag
    typedef struct packed {
        pp_array_t   pp;
        parity_tag_t tag;
    } decode_word_t;

    // second stage payload, resolved product plus tag
    typedef struct packed {
        product_t    prod;
        parity_tag_t tag;
    } result_word_t;

endpackage

// File: rtl/parity_pkg.sv
// parity package: tag mode encoding and the 2-bit tag carried with each result
package parity_pkg;

    // tag mode held in the register block
    typedef enum logic [1:0] {
        PAR_NONE = 2'b00,   // tag forced to 00
        PAR_EVEN = 2'b01,   // even parity bit, flag 0
        PAR_ODD  = 2'b10,   // odd parity bit, flag 1
        PAR_INV  = 2'b11    // inverted odd bit, flag 1
    } parity_mode_t;

    // upper bit parity, lower bit odd-family flag
    typedef struct packed {
        logic parity_bit;
        logic odd_flag;
    } parity_tag_t;

endpackage

// File: rtl/pmu_config.svh
// pmu config: width and size constants shared by the multiply unit
`ifndef PMU_CONFIG_SVH
`define PMU_CONFIG_SVH

// operand width of multiplier and multiplicand
`define PMU_OP_W 8

// full product width, twice the operand width
`define PMU_PROD_W 16

// radix-4 booth digits, one per operand bit pair
`define PMU_DIGITS 4

// delivered-result counter width
`define PMU_CNT_W 16

`endif
